/* vlog.f */
design/rv_pkg.sv
design/core_pkg.sv
design/mem_bus_if.sv
design/fetch_unit.sv
design/decoder.sv
design/exec_unit.sv
design/regfile.sv
design/lsu.sv
design/bus_arbiter.sv
design/rv_core.sv
test/rv_core_sva.sv
test/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - design/rv_pkg.sv
  - design/core_pkg.sv
  - design/mem_bus_if.sv
  - design/fetch_unit.sv
  - design/decoder.sv
  - design/exec_unit.sv
  - design/regfile.sv
  - design/lsu.sv
  - design/bus_arbiter.sv
  - design/rv_core.sv
  - target: test
    files:
      - test/rv_core_sva.sv
      - test/tb_rv_core.sv

/* test/tb_rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

    localparam int num_programs = 20;
    // each program runs once without and once with wait states
    localparam int num_runs     = 2 * num_programs;
    localparam int cycle_limit  = num_runs * 256 * 12;

    typedef enum int {
        k_addi, k_andi, k_ori, k_xori, k_add,
        k_sub, k_and, k_or, k_xor, k_lui,
        k_lw, k_sw, k_beq, k_bne, k_jal
    } kind_e;

    logic  inst_selfdefine = 1'b0;
    logic  reset;
    logic  mem_valid;
    logic  mem_ready;
    logic  mem_we;
    word_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;

    kind_e prog_kind [256];
    int    prog_rd [256];
    int    prog_rs1 [256];
    int    prog_rs2 [256];
    int    prog_imm [256];
    int    prog_len;

    word_t init_mem [512];
    word_t mem [512];
    word_t exp_fetch [$];
    word_t exp_ld_addr [$];
    word_t exp_st_addr [$];
    word_t exp_st_data [$];

    int    max_stall = 0;
    int    stall_cnt;
    int    cycle_count = 0;
    int    fetch_idx;
    int    load_idx;
    int    store_idx;
    int    run_errors;
    int    runs_passed = 0;
    int    runs_failed = 0;
    int    sva_fails;
    logic  run_active = 1'b0;
    logic  prog_done;
    word_t last_fetch;

    rv_core #(
        .reset_pc (32'h0)
    ) u_dut (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .mem_valid       (mem_valid),
        .mem_ready       (mem_ready),
        .mem_we          (mem_we),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata)
    );

    always #10 inst_selfdefine = ~inst_selfdefine;

    // memory model with random wait states
    always @(posedge inst_selfdefine) begin
        if (reset) begin
            mem_ready <= 1'b0;
            stall_cnt <= int'($urandom % (max_stall + 1));
        end else if (mem_ready) begin
            mem_ready <= 1'b0;
            stall_cnt <= int'($urandom % (max_stall + 1));
            if (mem_we) begin
                mem[mem_addr[10:2]] <= mem_wdata;
            end
        end else if (mem_valid) begin
            if (stall_cnt == 0) begin
                mem_ready <= 1'b1;
                mem_rdata <= mem[mem_addr[10:2]];
            end else begin
                stall_cnt <= stall_cnt - 1;
            end
        end
    end

    // monitor of completed bus transactions
    always @(negedge inst_selfdefine) begin
        if (run_active && !reset && !prog_done && mem_valid && mem_ready) begin
            if (mem_addr >= 32'h800 || mem_addr[1:0] != 2'b00) begin
                $display("** Error at %0t: access to %h outside the test memory",
                         $time, mem_addr);
                run_errors++;
            end else if (mem_we) begin
                if (store_idx >= exp_st_addr.size()) begin
                    $display("** Error at %0t: unexpected store of %h to %h",
                             $time, mem_wdata, mem_addr);
                    run_errors++;
                end else begin
                    if (mem_addr != exp_st_addr[store_idx]
                        || mem_wdata != exp_st_data[store_idx]) begin
                        $display("** Error at %0t: store %0d wrote %h to %h, expected %h to %h",
                                 $time, store_idx, mem_wdata, mem_addr,
                                 exp_st_data[store_idx], exp_st_addr[store_idx]);
                        run_errors++;
                    end
                    store_idx++;
                end
            end else if (mem_addr < 32'h400) begin
                // jal x0,0 at the end fetches itself again
                if (fetch_idx > 0 && mem_addr == last_fetch) begin
                    prog_done = 1'b1;
                end else if (fetch_idx >= exp_fetch.size()) begin
                    $display("** Error at %0t: unexpected fetch at %h", $time, mem_addr);
                    run_errors++;
                end else begin
                    if (mem_addr != exp_fetch[fetch_idx]) begin
                        $display("** Error at %0t: fetch %0d at %h, expected %h",
                                 $time, fetch_idx, mem_addr, exp_fetch[fetch_idx]);
                        run_errors++;
                    end
                    fetch_idx++;
                end
                last_fetch = mem_addr;
            end else if (load_idx >= exp_ld_addr.size()) begin
                $display("** Error at %0t: unexpected load from %h", $time, mem_addr);
                run_errors++;
            end else begin
                if (mem_addr != exp_ld_addr[load_idx]) begin
                    $display("** Error at %0t: load %0d from %h, expected %h",
                             $time, load_idx, mem_addr, exp_ld_addr[load_idx]);
                    run_errors++;
                end
                load_idx++;
            end
        end
    end

    always @(posedge inst_selfdefine) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic int data_imm();
        return 32'h400 + 4 * int'($urandom % 256);
    endfunction

    function automatic word_t encode(input int i);
        word_t      imm;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        imm = word_t'(prog_imm[i]);
        rd  = 5'(prog_rd[i]);
        rs1 = 5'(prog_rs1[i]);
        rs2 = 5'(prog_rs2[i]);
        case (prog_kind[i])
            k_addi: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            k_andi: return {imm[11:0], rs1, 3'b111, rd, 7'b0010011};
            k_ori:  return {imm[11:0], rs1, 3'b110, rd, 7'b0010011};
            k_xori: return {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
            k_add:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            k_sub:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            k_and:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            k_or:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            k_xor:  return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            k_lui:  return {imm[19:0], rd, 7'b0110111};
            k_lw:   return {imm[11:0], 5'd0, 3'b010, rd, 7'b0000011};
            k_sw:   return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
            k_beq:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            k_bne:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            default: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
        endcase
    endfunction

    task automatic gen_program();
        int i;
        int sel;
        int room;
        prog_len = 24 + int'($urandom % 40);
        i = 0;
        while (i < prog_len - 1) begin
            sel  = int'($urandom % 16);
            room = prog_len - 1 - i;
            prog_rd[i]  = int'($urandom % 8);
            prog_rs1[i] = int'($urandom % 8);
            prog_rs2[i] = ($urandom % 4 == 0) ? prog_rs1[i] : int'($urandom % 8);
            prog_imm[i] = int'($urandom % 4096) - 2048;
            if (sel == 15 && room >= 2) begin
                // load, then store the loaded register elsewhere
                prog_kind[i]   = k_lw;
                prog_rd[i]     = 1 + int'($urandom % 7);
                prog_imm[i]    = data_imm();
                prog_kind[i+1] = k_sw;
                prog_rs2[i+1]  = prog_rd[i];
                prog_imm[i+1]  = data_imm();
                i = i + 2;
            end else begin
                prog_kind[i] = kind_e'(sel % 15);
                case (prog_kind[i])
                    k_lui: prog_imm[i] = int'($urandom % 32'h100000);
                    k_lw, k_sw: prog_imm[i] = data_imm();
                    k_beq, k_bne, k_jal: begin
                        prog_imm[i] = 4 * (1 + int'($urandom % ((room < 4) ? room : 4)));
                    end
                    default: ;
                endcase
                i = i + 1;
            end
        end
        prog_kind[prog_len-1] = k_jal;
        prog_rd[prog_len-1]   = 0;
        prog_imm[prog_len-1]  = 0;
        for (int j = 0; j < 512; j++) begin
            init_mem[j] = (j < prog_len) ? encode(j) : $urandom;
        end
    endtask

    // reference ISS over the generated program
    task automatic run_iss();
        word_t x [32];
        word_t dmem [256];
        word_t a;
        word_t b;
        word_t imm;
        word_t res;
        int    p;
        int    next_p;
        logic  wr;
        exp_fetch.delete();
        exp_ld_addr.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
        for (int j = 0; j < 32; j++) begin
            x[j] = '0;
        end
        for (int j = 0; j < 256; j++) begin
            dmem[j] = init_mem[256 + j];
        end
        p = 0;
        while (p != prog_len - 1) begin
            exp_fetch.push_back(word_t'(p * 4));
            a      = x[prog_rs1[p]];
            b      = x[prog_rs2[p]];
            imm    = word_t'(prog_imm[p]);
            next_p = p + 1;
            wr     = 1'b1;
            res    = '0;
            case (prog_kind[p])
                k_addi: res = a + imm;
                k_andi: res = a & imm;
                k_ori:  res = a | imm;
                k_xori: res = a ^ imm;
                k_add:  res = a + b;
                k_sub:  res = a - b;
                k_and:  res = a & b;
                k_or:   res = a | b;
                k_xor:  res = a ^ b;
                k_lui:  res = imm << 12;
                k_lw: begin
                    res = dmem[(prog_imm[p] >> 2) - 256];
                    exp_ld_addr.push_back(imm);
                end
                k_sw: begin
                    wr = 1'b0;
                    exp_st_addr.push_back(imm);
                    exp_st_data.push_back(b);
                    dmem[(prog_imm[p] >> 2) - 256] = b;
                end
                k_beq, k_bne: begin
                    wr = 1'b0;
                    if ((a == b) ^ (prog_kind[p] == k_bne)) begin
                        next_p = p + prog_imm[p] / 4;
                    end
                end
                default: begin
                    res    = word_t'((p + 1) * 4);
                    next_p = p + prog_imm[p] / 4;
                end
            endcase
            if (wr && prog_rd[p] != 0) begin
                x[prog_rd[p]] = res;
            end
            p = next_p;
        end
        exp_fetch.push_back(word_t'(p * 4));
    endtask

    task automatic run_test(input int test_no, input int stall);
        @(posedge inst_selfdefine);
        reset <= 1'b1;
        repeat (2) @(posedge inst_selfdefine);
        for (int j = 0; j < 512; j++) begin
            mem[j] = init_mem[j];
        end
        max_stall  = stall;
        fetch_idx  = 0;
        load_idx   = 0;
        store_idx  = 0;
        run_errors = 0;
        prog_done  = 1'b0;
        run_active = 1'b1;
        repeat (3) @(posedge inst_selfdefine);
        reset <= 1'b0;
        while (!prog_done) begin
            @(posedge inst_selfdefine);
        end
        run_active = 1'b0;
        if (fetch_idx != exp_fetch.size() || load_idx != exp_ld_addr.size()
            || store_idx != exp_st_addr.size()) begin
            $display("** Error at %0t: ended after %0d of %0d fetches, %0d of %0d loads, %0d of %0d stores",
                     $time, fetch_idx, exp_fetch.size(), load_idx, exp_ld_addr.size(),
                     store_idx, exp_st_addr.size());
            run_errors++;
        end
        if (run_errors == 0) begin
            runs_passed++;
        end else begin
            runs_failed++;
        end
        $display("test %0d, %s stalls: %s, %0d fetches, %0d loads, %0d stores", test_no,
                 (stall == 0) ? "zero" : "random", (run_errors == 0) ? "ok" : "failed",
                 fetch_idx, load_idx, store_idx);
    endtask

    initial begin
        void'($urandom(57));
        reset     <= 1'b1;
        mem_ready <= 1'b0;
        mem_rdata <= '0;
        for (int t = 0; t < num_programs; t++) begin
            gen_program();
            run_iss();
            run_test(t, 0);
            run_test(t, 3);
        end
        sva_fails = u_dut.u_bus_arbiter.u_rv_core_sva.fail_count;
        $display("runs passed %0d, failed %0d, assertion failures %0d",
                 runs_passed, runs_failed, sva_fails);
        if (runs_failed == 0 && sva_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/rv_core_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_sva import rv_pkg::*; (
    input wire logic  inst_selfdefine,
    input wire logic  reset,
    input wire logic  mem_valid,
    input wire logic  mem_ready,
    input wire logic  mem_we,
    input wire word_t mem_addr,
    input wire word_t mem_wdata,
    input wire logic  fetch_valid,
    input wire logic  fetch_ready,
    input wire logic  data_valid,
    input wire logic  data_ready,
    input wire logic  busy,
    input wire logic  grant_data
);

    int fail_count = 0;

    // open request keeps its fields until ready
    a_req_hold: assert property (@(posedge inst_selfdefine) disable iff (reset)
        (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_addr)
            && $stable(mem_we) && $stable(mem_wdata)))
    else begin
        $error("bus request changed before ready");
        fail_count++;
    end

    // ready only to a side with an open request
    a_fetch_owner: assert property (@(posedge inst_selfdefine) disable iff (reset)
        fetch_ready |-> fetch_valid)
    else begin
        $error("ready reached the fetch side without its grant");
        fail_count++;
    end

    a_data_owner: assert property (@(posedge inst_selfdefine) disable iff (reset)
        data_ready |-> data_valid)
    else begin
        $error("ready reached the data side without its grant");
        fail_count++;
    end

    // locked grant belongs to the side that is requesting
    a_grant_lock: assert property (@(posedge inst_selfdefine) disable iff (reset)
        busy |-> (grant_data ? data_valid : fetch_valid))
    else begin
        $error("bus grant is locked to a side without a request");
        fail_count++;
    end

    // first reset cycle still carries the old request
    a_reset_idle: assert property (@(posedge inst_selfdefine)
        (reset && $past(reset)) |-> !mem_valid)
    else begin
        $error("bus request raised during reset");
        fail_count++;
    end

endmodule

bind bus_arbiter rv_core_sva u_rv_core_sva (
    .inst_selfdefine (inst_selfdefine),
    .reset           (reset),
    .mem_valid       (mem_valid),
    .mem_ready       (mem_ready),
    .mem_we          (mem_we),
    .mem_addr        (mem_addr),
    .mem_wdata       (mem_wdata),
    .fetch_valid     (fetch_bus.valid),
    .fetch_ready     (fetch_bus.ready),
    .data_valid      (data_bus.valid),
    .data_ready      (data_bus.ready),
    .busy            (busy),
    .grant_data      (grant_data)
);

`default_nettype wire

/* design/rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_pkg::*; import core_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  wire logic inst_selfdefine,
    input  wire logic reset,
    output logic      mem_valid,
    input  wire logic mem_ready,
    output logic      mem_we,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    input  word_t     mem_rdata
);

    decoded_t dec;
    word_t    pc;
    word_t    instr;
    word_t    next_pc;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    load_data;
    logic     mem_start;
    logic     mem_done;
    logic     retire;
    logic     rf_we;
    reg_idx_t rf_rd;
    word_t    rf_data;

    mem_bus_if fetch_bus ();
    mem_bus_if data_bus ();

    fetch_unit #(
        .reset_pc (reset_pc)
    ) u_fetch_unit (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .fetch_bus       (fetch_bus.requester),
        .dec             (dec),
        .next_pc         (next_pc),
        .mem_done        (mem_done),
        .pc              (pc),
        .instr           (instr),
        .mem_start       (mem_start),
        .retire          (retire)
    );

    decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    regfile u_regfile (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .rs1             (dec.rs1),
        .rs2             (dec.rs2),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .we              (rf_we),
        .rd              (rf_rd),
        .rd_data         (rf_data)
    );

    exec_unit u_exec_unit (
        .dec       (dec),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .load_data (load_data),
        .retire    (retire),
        .next_pc   (next_pc),
        .rf_we     (rf_we),
        .rf_rd     (rf_rd),
        .rf_data   (rf_data)
    );

    lsu u_lsu (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .dec             (dec),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .mem_start       (mem_start),
        .data_bus        (data_bus.requester),
        .mem_done        (mem_done),
        .load_data       (load_data)
    );

    bus_arbiter u_bus_arbiter (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .fetch_bus       (fetch_bus.responder),
        .data_bus        (data_bus.responder),
        .mem_valid       (mem_valid),
        .mem_ready       (mem_ready),
        .mem_we          (mem_we),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata)
    );

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter import rv_pkg::*; (
    input  wire logic    inst_selfdefine,
    input  wire logic    reset,
    mem_bus_if.responder fetch_bus,
    mem_bus_if.responder data_bus,
    output logic         mem_valid,
    input  wire logic    mem_ready,
    output logic         mem_we,
    output word_t        mem_addr,
    output word_t        mem_wdata,
    input  word_t        mem_rdata
);

    logic busy;
    logic grant_data;
    logic sel_data;

    // locked owner while open, otherwise data side wins
    assign sel_data = busy ? grant_data : data_bus.valid;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            busy       <= 1'b0;
            grant_data <= 1'b0;
        end else if (!busy) begin
            if (mem_valid && !mem_ready) begin
                busy       <= 1'b1;
                grant_data <= sel_data;
            end
        end else if (mem_ready) begin
            busy <= 1'b0;
        end
    end

    assign mem_valid = sel_data ? data_bus.valid : fetch_bus.valid;
    assign mem_we    = sel_data ? data_bus.we    : fetch_bus.we;
    assign mem_addr  = sel_data ? data_bus.addr  : fetch_bus.addr;
    assign mem_wdata = sel_data ? data_bus.wdata : fetch_bus.wdata;

    assign fetch_bus.ready = mem_ready & ~sel_data;
    assign data_bus.ready  = mem_ready & sel_data;
    assign fetch_bus.rdata = mem_rdata;
    assign data_bus.rdata  = mem_rdata;

endmodule

`default_nettype wire

/* design/lsu.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu import rv_pkg::*; import core_pkg::*; (
    input  wire logic    inst_selfdefine,
    input  wire logic    reset,
    input  decoded_t     dec,
    input  word_t        rs1_data,
    input  word_t        rs2_data,
    input  wire logic    mem_start,
    mem_bus_if.requester data_bus,
    output logic         mem_done,
    output word_t        load_data
);

    logic  req_valid;
    logic  req_we;
    word_t req_addr;
    word_t req_wdata;
    word_t eff_addr;

    assign eff_addr = rs1_data + dec.imm;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            req_valid <= 1'b0;
            req_we    <= 1'b0;
        end else if (mem_start) begin
            req_valid <= 1'b1;
            req_we    <= dec.is_store;
        end else if (data_bus.ready) begin
            req_valid <= 1'b0;
        end
    end

    // word access only, low bits dropped
    always_ff @(posedge inst_selfdefine) begin
        if (mem_start) begin
            req_addr  <= {eff_addr[31:2], 2'b00};
            req_wdata <= rs2_data;
        end
    end

    assign data_bus.valid = req_valid;
    assign data_bus.we    = req_we;
    assign data_bus.addr  = req_addr;
    assign data_bus.wdata = req_wdata;

    assign mem_done  = req_valid & data_bus.ready;
    assign load_data = data_bus.rdata;

endmodule

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module regfile import rv_pkg::*; (
    input  wire logic inst_selfdefine,
    input  wire logic reset,
    input  reg_idx_t  rs1,
    input  reg_idx_t  rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  wire logic we,
    input  reg_idx_t  rd,
    input  word_t     rd_data
);

    word_t regs [32];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* design/exec_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_unit import rv_pkg::*; import core_pkg::*; (
    input  decoded_t  dec,
    input  word_t     pc,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  word_t     load_data,
    input  wire logic retire,
    output word_t     next_pc,
    output logic      rf_we,
    output reg_idx_t  rf_rd,
    output word_t     rf_data
);

    word_t op_b;
    word_t alu_res;
    word_t pc_plus4;
    logic  taken;

    assign op_b     = dec.use_imm ? dec.imm : rs2_data;
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (dec.alu_op)
            alu_sub: alu_res = rs1_data - op_b;
            alu_and: alu_res = rs1_data & op_b;
            alu_or:  alu_res = rs1_data | op_b;
            alu_xor: alu_res = rs1_data ^ op_b;
            alu_pass_b: alu_res = op_b;
            default: alu_res = rs1_data + op_b;
        endcase
    end

    // bne inverts the equality test
    assign taken   = dec.is_jal | (dec.is_branch & ((rs1_data == rs2_data) ^ dec.branch_ne));
    assign next_pc = taken ? pc + dec.imm : pc_plus4;

    assign rf_we   = retire & dec.rd_we;
    assign rf_rd   = dec.rd;
    assign rf_data = dec.is_jal ? pc_plus4 : (dec.is_load ? load_data : alu_res);

endmodule

`default_nettype wire

/* design/decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module decoder import rv_pkg::*; import core_pkg::*; (
    input  word_t    instr,
    output decoded_t dec
);

    opcode_e    opc;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opc    = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec        = '0;
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.rd     = instr[11:7];
        dec.alu_op = alu_add;
        case (opc)
            opc_op_imm: begin
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                dec.rd_we   = 1'b1;
                case (funct3)
                    f3_add:  dec.alu_op = alu_add;
                    f3_xor:  dec.alu_op = alu_xor;
                    f3_or:   dec.alu_op = alu_or;
                    f3_and:  dec.alu_op = alu_and;
                    // shifts and slti fall through as no-ops
                    default: dec.rd_we  = 1'b0;
                endcase
            end
            opc_op: begin
                dec.rd_we = (funct7 == 7'b0000000);
                case (funct3)
                    f3_add: begin
                        dec.rd_we  = (funct7 == 7'b0000000) | (funct7 == 7'b0100000);
                        dec.alu_op = funct7[5] ? alu_sub : alu_add;
                    end
                    f3_xor:  dec.alu_op = alu_xor;
                    f3_or:   dec.alu_op = alu_or;
                    f3_and:  dec.alu_op = alu_and;
                    default: dec.rd_we  = 1'b0;
                endcase
            end
            opc_lui: begin
                dec.alu_op  = alu_pass_b;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.rd_we   = 1'b1;
            end
            opc_load: begin
                dec.imm     = imm_i;
                dec.is_load = (funct3 == f3_word);
                dec.rd_we   = (funct3 == f3_word);
            end
            opc_store: begin
                dec.imm      = imm_s;
                dec.is_store = (funct3 == f3_word);
            end
            opc_branch: begin
                dec.imm       = imm_b;
                dec.is_branch = (funct3 == f3_beq) | (funct3 == f3_bne);
                dec.branch_ne = (funct3 == f3_bne);
            end
            opc_jal: begin
                dec.imm    = imm_j;
                dec.is_jal = 1'b1;
                dec.rd_we  = 1'b1;
            end
            default: ;
        endcase
        // x0 never written
        if (dec.rd == '0) begin
            dec.rd_we = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import rv_pkg::*; import core_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  wire logic     inst_selfdefine,
    input  wire logic     reset,
    mem_bus_if.requester  fetch_bus,
    input  decoded_t      dec,
    input  word_t         next_pc,
    input  wire logic     mem_done,
    output word_t         pc,
    output word_t         instr,
    output logic          mem_start,
    output logic          retire
);

    phase_e phase;
    logic   fetch_valid;
    logic   mem_op;

    assign mem_op = dec.is_load | dec.is_store;

    assign fetch_bus.valid = fetch_valid;
    assign fetch_bus.we    = 1'b0;
    assign fetch_bus.addr  = pc;
    assign fetch_bus.wdata = '0;

    assign mem_start = (phase == ph_exec) & mem_op;
    assign retire    = ((phase == ph_exec) & ~mem_op) | ((phase == ph_mem) & mem_done);

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            phase       <= ph_fetch;
            fetch_valid <= 1'b0;
            pc          <= reset_pc;
        end else begin
            case (phase)
                ph_fetch: begin
                    // first request after reset
                    if (!fetch_valid) begin
                        fetch_valid <= 1'b1;
                    end else if (fetch_bus.ready) begin
                        fetch_valid <= 1'b0;
                        phase       <= ph_exec;
                    end
                end
                ph_exec: begin
                    if (mem_op) begin
                        phase <= ph_mem;
                    end else begin
                        phase       <= ph_fetch;
                        fetch_valid <= 1'b1;
                    end
                end
                default: begin
                    if (mem_done) begin
                        phase       <= ph_fetch;
                        fetch_valid <= 1'b1;
                    end
                end
            endcase
            if (retire) begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (phase == ph_fetch && fetch_bus.ready) begin
            instr <= fetch_bus.rdata;
        end
    end

endmodule

`default_nettype wire

/* design/mem_bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if import rv_pkg::*; ();

    logic  valid;
    logic  ready;
    logic  we;
    word_t addr;
    word_t wdata;
    word_t rdata;

    modport requester (
        output valid,
        output we,
        output addr,
        output wdata,
        input  ready,
        input  rdata
    );

    modport responder (
        input  valid,
        input  we,
        input  addr,
        input  wdata,
        output ready,
        output rdata
    );

endinterface

`default_nettype wire

/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

    import rv_pkg::*;

    typedef enum logic [1:0] {
        ph_fetch,
        ph_exec,
        ph_mem
    } phase_e;

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     rd_we;
        alu_op_e  alu_op;
        logic     use_imm;
        word_t    imm;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
        logic     branch_ne;
        logic     is_jal;
    } decoded_t;

endpackage

`default_nettype wire

/* design/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        // lui result is the immediate itself
        alu_pass_b
    } alu_op_e;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    // lw and sw
    localparam logic [2:0] f3_word = 3'b010;

endpackage

`default_nettype wire
